// ==== sifhPkg.sv ====
package sifhPkg;

    localparam int TS_W             = 8;  // tdc timestamp width
    localparam int BIN_W            = 4;  // bin index width
    localparam int NUM_BINS         = 16;
    localparam int COUNT_W          = 5;  // holds a full pass in one bin
    localparam int SAMPLES_PER_PASS = 16;

    typedef logic [TS_W-1:0]    tsT;
    typedef logic [BIN_W-1:0]   binT;
    typedef logic [COUNT_W-1:0] countT;

    // bin mapping of the current pass
    typedef enum logic {
        PH_COARSE,
        PH_FINE
    } phaseT;

    // command from the sequencer to the histogram engine
    typedef enum logic [1:0] {
        ENG_IDLE,
        ENG_CLEAR,
        ENG_BUILD,
        ENG_SCAN
    } engModeT;

    typedef enum logic [2:0] {
        IDLE,
        CLEAR,
        BUILD,
        DRAIN,
        SCAN,
        FILTER,
        DONE
    } seqStateT;

endpackage

// ==== sramPort.sv ====
`timescale 1ns/1ns

interface sramPort;
    import sifhPkg::*;

    binT   wAddr;
    countT wData;
    logic  wEn;
    binT   rAddr;
    logic  rEn;
    countT rData;  // valid one cycle after rEn

    modport client (
        output wAddr,
        output wData,
        output wEn,
        output rAddr,
        output rEn,
        input  rData
    );

    modport memory (
        input  wAddr,
        input  wData,
        input  wEn,
        input  rAddr,
        input  rEn,
        output rData
    );

endinterface

// ==== histSram.sv ====
`timescale 1ns/1ns

module histSram (
    input logic    clk,
    sramPort.memory mem
);
    import sifhPkg::*;

    countT ram [NUM_BINS];

    always_ff @(posedge clk) begin
        if (mem.wEn) begin
            ram[mem.wAddr] <= mem.wData;
        end
        if (mem.rEn) begin
            mem.rData <= ram[mem.rAddr];  // old word on a same-address write
        end
    end

    // both addresses come from the engine, an X here corrupts a bin silently
    addrKnown: assert property (
        @(posedge clk)
        !((mem.wEn && $isunknown(mem.wAddr)) || (mem.rEn && $isunknown(mem.rAddr)))
    ) else $error("histSram: unknown address with enable high");

endmodule

// ==== sweepCounter.sv ====
`timescale 1ns/1ns

module sweepCounter #(
    parameter int LAST = 15
) (
    input  logic                         clk,
    input  logic                         res,
    input  logic                         clear,
    input  logic                         en,
    output logic [$clog2(LAST+1)-1:0]    value,
    output logic                         last
);

    assign last = (value == LAST);

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            value <= '0;
        end else if (clear) begin
            value <= '0;  // clear wins over en
        end else if (en) begin
            if (last) begin
                value <= '0;  // wrap after LAST
            end else begin
                value <= value + 1'b1;
            end
        end
    end

endmodule

// ==== sifhSequencer.sv ====
`timescale 1ns/1ns

module sifhSequencer (
    input  logic             clk,
    input  logic             res,
    input  logic             start,
    input  logic             dataValid,
    input  logic             peakValid,
    output sifhPkg::engModeT mode,
    output sifhPkg::phaseT   phase,
    output sifhPkg::binT     sweepAddr,
    output logic             ready,
    output logic             done
);
    import sifhPkg::*;

    seqStateT state;
    seqStateT nextState;
    logic     cntClear;
    logic     binEn;
    logic     binLast;
    logic     sampleEn;
    logic     sampleLast;
    logic     scanIssued;  // set once all scan reads are sent

    always_comb begin
        nextState = state;
        case (state)
            IDLE:    if (start) nextState = CLEAR;
            CLEAR:   if (binLast) nextState = BUILD;
            BUILD:   if (dataValid && sampleLast) nextState = DRAIN;
            DRAIN:   if (sweepAddr == binT'(1)) nextState = SCAN;  // two cycles
            SCAN: begin
                if (peakValid) begin
                    if (phase == PH_COARSE) begin
                        nextState = FILTER;
                    end else begin
                        nextState = DONE;
                    end
                end
            end
            FILTER:  nextState = CLEAR;  // winBase settles here
            DONE:    nextState = IDLE;
            default: nextState = IDLE;
        endcase
    end

    assign cntClear = (nextState != state);  // fresh count on every phase entry
    assign binEn    = (state == CLEAR) || (state == DRAIN) || ((state == SCAN) && !scanIssued);
    assign sampleEn = (state == BUILD) && dataValid;

    always_comb begin
        case (state)
            CLEAR:   mode = ENG_CLEAR;
            BUILD:   mode = ENG_BUILD;
            SCAN:    mode = scanIssued ? ENG_IDLE : ENG_SCAN;
            default: mode = ENG_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            state      <= IDLE;
            phase      <= PH_COARSE;
            scanIssued <= 1'b0;
            ready      <= 1'b0;
            done       <= 1'b0;
        end else begin
            state <= nextState;
            ready <= (nextState == BUILD);
            done  <= (nextState == DONE);
            if (state == IDLE && start) begin
                phase <= PH_COARSE;
            end else if (state == FILTER) begin
                phase <= PH_FINE;
            end
            if (state != SCAN) begin
                scanIssued <= 1'b0;
            end else if (binLast) begin
                scanIssued <= 1'b1;
            end
        end
    end

    sweepCounter #(
        .LAST(NUM_BINS - 1)
    ) binCounter (
        .clk  (clk),
        .res  (res),
        .clear(cntClear),
        .en   (binEn),
        .value(sweepAddr),
        .last (binLast)
    );

    sweepCounter #(
        .LAST(SAMPLES_PER_PASS - 1)
    ) sampleCounter (
        .clk  (clk),
        .res  (res),
        .clear(cntClear),
        .en   (sampleEn),
        .value(),
        .last (sampleLast)
    );

    // the tdc is asked for one pass worth of strobes and no more
    readyEndsPass: assert property (
        @(posedge clk) disable iff (!res) ready && dataValid && sampleLast |=> !ready
    ) else $error("sifhSequencer: ready still high after the last sample of a pass");

endmodule

// ==== histogramEngine.sv ====
`timescale 1ns/1ns

module histogramEngine (
    input  logic             clk,
    input  logic             res,
    input  sifhPkg::engModeT mode,
    input  sifhPkg::phaseT   phase,
    input  sifhPkg::binT     sweepAddr,
    input  sifhPkg::tsT      data,
    input  logic             dataValid,
    input  sifhPkg::tsT      winBase,
    sramPort.client          mem,
    output logic             binValid,
    output sifhPkg::binT     binIdx,
    output sifhPkg::countT   binCount
);
    import sifhPkg::*;

    binT   sampleBin;
    logic  inWindow;
    logic  sampleHit;
    logic  s1Valid;   // stage one read in flight
    binT   s1Bin;
    logic  fwdValid;  // write of the previous cycle
    binT   fwdBin;
    countT fwdCount;
    countT oldCount;
    countT incCount;
    logic  wrEn;
    binT   wrBin;
    countT wrCount;
    logic  scanValid;
    binT   scanBin;

    assign inWindow  = (data[TS_W-1 -: BIN_W] == winBase[TS_W-1 -: BIN_W]);
    assign sampleBin = (phase == PH_COARSE) ? data[TS_W-1 -: BIN_W] : data[BIN_W-1:0];
    assign sampleHit = (mode == ENG_BUILD) && dataValid && ((phase == PH_COARSE) || inWindow);

    // sram returns the stale word when the same bin was written last cycle
    assign oldCount = (fwdValid && fwdBin == s1Bin) ? fwdCount : mem.rData;
    assign incCount = (oldCount == '1) ? oldCount : oldCount + 1'b1;

    always_comb begin
        wrEn    = s1Valid;
        wrBin   = s1Bin;
        wrCount = incCount;
        if (mode == ENG_CLEAR) begin
            wrEn    = 1'b1;
            wrBin   = sweepAddr;
            wrCount = '0;
        end
    end

    assign mem.wEn   = wrEn;
    assign mem.wAddr = wrBin;
    assign mem.wData = wrCount;
    assign mem.rEn   = sampleHit || (mode == ENG_SCAN);
    assign mem.rAddr = (mode == ENG_SCAN) ? sweepAddr : sampleBin;

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            s1Valid   <= 1'b0;
            fwdValid  <= 1'b0;
            scanValid <= 1'b0;
        end else begin
            s1Valid   <= sampleHit;
            fwdValid  <= wrEn;
            scanValid <= (mode == ENG_SCAN);
        end
    end

    always_ff @(posedge clk) begin
        s1Bin    <= sampleBin;
        fwdBin   <= wrBin;
        fwdCount <= wrCount;
        scanBin  <= sweepAddr;  // lines up with the registered read
    end

    assign binValid = scanValid;
    assign binIdx   = scanBin;
    assign binCount = mem.rData;

    // clear sweep or stage one bin, both must be known when written
    writeAddrKnown: assert property (
        @(posedge clk) disable iff (!res)
        wrEn |-> !$isunknown(wrBin)
    ) else $error("histogramEngine: write to an unknown bin");

endmodule

// ==== peakFinder.sv ====
`timescale 1ns/1ns

module peakFinder (
    input  logic           clk,
    input  logic           res,
    input  sifhPkg::phaseT phase,
    input  logic           binValid,
    input  sifhPkg::binT   binIdx,
    input  sifhPkg::countT binCount,
    output logic           peakValid,
    output sifhPkg::binT   peakBin,
    output sifhPkg::countT peakCount,
    output sifhPkg::tsT    winBase
);
    import sifhPkg::*;

    logic firstBin;
    logic lastBin;
    logic better;

    assign firstBin = (binIdx == '0);
    assign lastBin  = (binIdx == binT'(NUM_BINS - 1));
    assign better   = firstBin || (binCount > peakCount);  // strict, lowest bin keeps a tie

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            peakValid <= 1'b0;
            peakBin   <= '0;
            peakCount <= '0;
            winBase   <= '0;
        end else begin
            peakValid <= binValid && lastBin;
            if (binValid && better) begin
                peakBin   <= binIdx;
                peakCount <= binCount;
            end
            if (peakValid && phase == PH_COARSE) begin
                winBase <= {peakBin, {(TS_W - BIN_W){1'b0}}};  // whole coarse bin range
            end
        end
    end

endmodule

// ==== sifhTop.sv ====
`timescale 1ns/1ns

module sifhTop (
    input  logic           clk,
    input  logic           res,
    input  logic           start,
    input  sifhPkg::tsT    data,
    input  logic           dataValid,
    output logic           ready,
    output logic           done,
    output sifhPkg::tsT    peakTime,
    output sifhPkg::countT peakCount
);
    import sifhPkg::*;

    engModeT mode;
    phaseT   phase;
    binT     sweepAddr;
    logic    binValid;
    binT     binIdx;
    countT   binCount;
    logic    peakValid;
    binT     peakBin;
    countT   bestCount;
    tsT      winBase;

    sramPort sram ();

    sifhSequencer sequencer (
        .clk      (clk),
        .res      (res),
        .start    (start),
        .dataValid(dataValid),
        .peakValid(peakValid),
        .mode     (mode),
        .phase    (phase),
        .sweepAddr(sweepAddr),
        .ready    (ready),
        .done     (done)
    );

    histogramEngine engine (
        .clk      (clk),
        .res      (res),
        .mode     (mode),
        .phase    (phase),
        .sweepAddr(sweepAddr),
        .data     (data),
        .dataValid(dataValid),
        .winBase  (winBase),
        .mem      (sram.client),
        .binValid (binValid),
        .binIdx   (binIdx),
        .binCount (binCount)
    );

    peakFinder finder (
        .clk      (clk),
        .res      (res),
        .phase    (phase),
        .binValid (binValid),
        .binIdx   (binIdx),
        .binCount (binCount),
        .peakValid(peakValid),
        .peakBin  (peakBin),
        .peakCount(bestCount),
        .winBase  (winBase)
    );

    histSram memory (
        .clk(clk),
        .mem(sram.memory)
    );

    // fine peak is final on the same edge that raises done
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            peakTime  <= '0;
            peakCount <= '0;
        end else if (peakValid && phase == PH_FINE) begin
            peakTime  <= {winBase[TS_W-1 -: BIN_W], peakBin};
            peakCount <= bestCount;
        end
    end

endmodule

// ==== sifhTb.sv ====
`timescale 1ns/1ns

module sifhTb;
    import sifhPkg::*;

    localparam int FRAME_WORDS = 2 * SAMPLES_PER_PASS + 2;  // 32 timestamps, time and count
    localparam int WAIT_LIMIT  = 200;                        // cycles per wait

    logic  clk;
    logic  res;
    logic  start;
    tsT    data;
    logic  dataValid;
    logic  ready;
    logic  done;
    tsT    peakTime;
    countT peakCount;

    logic [7:0] stim [2 * FRAME_WORDS];
    integer     seed      = 34;
    int         errors    = 0;
    int         timeouts  = 0;
    int         runs      = 0;
    int         doneCount = 0;

    sifhTop DUT (
        .clk      (clk),
        .res      (res),
        .start    (start),
        .data     (data),
        .dataValid(dataValid),
        .ready    (ready),
        .done     (done),
        .peakTime (peakTime),
        .peakCount(peakCount)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(negedge clk) begin
        if (done === 1'b1) begin
            doneCount++;  // a wide pulse counts twice
        end
    end

    task check(input logic [31:0] actual, input logic [31:0] expected, input string what);
        if (actual !== expected) begin
            $display("FAILED at %0t ns: %s, got %0h, expected %0h", $time, what, actual, expected);
            errors++;
        end
    endtask

    task waitReady(input logic level);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (ready !== level && cycles < WAIT_LIMIT) begin
            @(posedge clk);
            dataValid <= 1'b0;
            @(negedge clk);
            cycles++;
        end
        if (ready !== level) begin
            $display("timeout at %0t ns: ready did not go to %0b", $time, level);
            timeouts++;
        end
    endtask

    task waitDone(input tsT heldTime, input countT heldCount);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (done !== 1'b1 && cycles < WAIT_LIMIT) begin
            check(peakTime, heldTime, "peakTime held before done");
            check(peakCount, heldCount, "peakCount held before done");
            @(negedge clk);
            cycles++;
        end
        if (done !== 1'b1) begin
            $display("timeout at %0t ns: done did not pulse", $time);
            timeouts++;
        end
    endtask

    // strobes while ready is low, the DUT must drop them
    task sendJunk(input int n);
        repeat (n) begin
            @(posedge clk);
            data      <= tsT'($random(seed));
            dataValid <= 1'b1;
        end
        @(posedge clk);
        dataValid <= 1'b0;
    endtask

    task sendPass(input int base);
        int sent;
        sent = 0;
        waitReady(1'b1);
        while (sent < SAMPLES_PER_PASS) begin
            @(posedge clk);
            if (($random(seed) & 3) == 0) begin
                dataValid <= 1'b0;  // idle gap
            end else begin
                data      <= stim[base + sent];
                dataValid <= 1'b1;
                sent++;
            end
            @(negedge clk);
            check(ready, 1'b1, "ready during a pass");
        end
        @(posedge clk);
        dataValid <= 1'b0;
    endtask

    task runFrame(input int frame);
        int    base;
        tsT    heldTime;
        countT heldCount;
        base = frame * FRAME_WORDS;
        @(negedge clk);
        heldTime  = peakTime;
        heldCount = peakCount;
        @(posedge clk);
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        sendJunk(3);  // lands in CLEAR
        sendPass(base);
        waitReady(1'b0);
        sendJunk(3);  // drain and coarse scan
        sendPass(base + SAMPLES_PER_PASS);
        waitReady(1'b0);
        sendJunk(3);
        waitDone(heldTime, heldCount);
        runs++;
        check(peakTime, stim[base + FRAME_WORDS - 2], "peakTime");
        check(peakCount, stim[base + FRAME_WORDS - 1], "peakCount");
        repeat (6) begin
            @(posedge clk);
            data      <= tsT'($random(seed));
            dataValid <= 1'b1;  // DUT back in IDLE
            @(negedge clk);
            check(done, 1'b0, "done after its pulse");
            check(peakTime, stim[base + FRAME_WORDS - 2], "peakTime after done");
        end
        @(posedge clk);
        dataValid <= 1'b0;
        check(doneCount, runs, "done pulses per start");
    endtask

    initial begin
        res       = 1'b0;
        start     = 1'b0;
        data      = '0;
        dataValid = 1'b0;
        $readmemh("sifhInput.txt", stim);
        repeat (16) @(posedge clk);
        res <= 1'b1;
        repeat (8) begin
            @(posedge clk);
            data      <= tsT'($random(seed));
            dataValid <= 1'b1;  // no start yet
            @(negedge clk);
            check(ready, 1'b0, "ready before start");
            check(done, 1'b0, "done before start");
        end
        @(posedge clk);
        dataValid <= 1'b0;
        runFrame(0);  // clear peak, back-to-back hits
        runFrame(1);  // coarse tie, samples outside the window
        runFrame(0);  // same result after a different histogram
        $display("checks failed: %0d, timeouts: %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// ==== sifhInput.txt ====
// one hex timestamp per line, 16 for the coarse pass then 16 for the fine pass
// last line of a frame: expected peakTime and peakCount
53
53
57
5A
21
5F
50
92
53
25
5C
96
2E
58
9B
2A
5C
5C
5C
5C
53
53
5C
51
5C
53
5E
5C
53
51
5C
5E
5C 08
A1
A4
37
30
AF
3B
72
3C
A8
35
7E
AA
33
71
A0
7D
A2
39
39
72
32
A6
39
A2
32
A6
3F
72
39
A6
32
A2
39 04

// ==== sifhTop.f ====
sifhPkg.sv
sramPort.sv
histSram.sv
sweepCounter.sv
sifhSequencer.sv
histogramEngine.sv
peakFinder.sv
sifhTop.sv
sifhTb.sv

// ==== Bender.yml ====
package:
  name: sifh

sources:
  - sifhPkg.sv
  - sramPort.sv
  - histSram.sv
  - sweepCounter.sv
  - sifhSequencer.sv
  - histogramEngine.sv
  - peakFinder.sv
  - sifhTop.sv
  - target: test
    files:
      - sifhTb.sv
